// File: verilog/plat_pkg.sv
// ======================================================================
// Platform constants and the structs shared by the emulator, the banks
// and the AFU. Both bank groups share one address width. The group-1
// word must not be wider than the group-0 word.
// ======================================================================

package plat_pkg;

  // Local memory geometry
  localparam int mem_addr_w = 8;
  localparam int g0_word_w = 64;
  localparam int g1_word_w = 32;

  // Read latency of each bank, counted from the edge that samples the request
  localparam int g0_read_latency = 2;
  localparam int g1_read_latency = 3;

  // Platform reset stays low this many cycles after a soft-reset request
  localparam int soft_reset_cycles = 4;

  // Power of two, so the AFU queue pointers wrap on their own
  localparam int afu_queue_depth = 4;

  typedef logic [g0_word_w-1:0] g0_word_t;
  typedef logic [g1_word_w-1:0] g1_word_t;

  // ====================================================================
  // Host channel
  // ====================================================================

  typedef enum logic [1:0] {
    op_wr_g0      = 2'd0,
    op_wr_g1      = 2'd1,
    op_rd         = 2'd2,
    op_soft_reset = 2'd3
  } host_op_t;

  typedef struct packed {
    host_op_t              op;
    logic [mem_addr_w-1:0] addr;
    g0_word_t              data;
  } host_cmd_t;

  typedef struct packed {
    logic [mem_addr_w-1:0] addr;
    g0_word_t              data;
  } host_rsp_t;

  // ====================================================================
  // Bank request, write data travels beside it
  // ====================================================================

  typedef struct packed {
    logic                  wr_en;
    logic [mem_addr_w-1:0] addr;
  } mem_req_t;

endpackage

// File: verilog/plat_reset_gen.sv
// ======================================================================
// Platform reset. Board reset or a soft-reset strobe drives soft_rst_n
// low. A strobe holds it low for soft_reset_cycles cycles, starting one
// edge after the strobe is sampled. The output is registered, so board
// reset reaches soft_rst_n one edge late.
// ======================================================================

`timescale 1ns/1ns

module plat_reset_gen
  (
    input  logic pClk,
    input  logic rst_n,
    input  logic soft_reset_req,
    output logic soft_rst_n
  );

  localparam int cnt_w = $clog2(plat_pkg::soft_reset_cycles + 1);

  // Cycles still to hold after the current one
  logic [cnt_w-1:0] hold_cnt;

  always_ff @(posedge pClk)
  begin
    if (!rst_n)
    begin
      hold_cnt   <= '0;
      soft_rst_n <= 1'b0;
    end
    else if (soft_reset_req)
    begin
      // First low cycle starts now, the counter covers the rest
      hold_cnt   <= cnt_w'(plat_pkg::soft_reset_cycles - 1);
      soft_rst_n <= 1'b0;
    end
    else if (hold_cnt != '0)
    begin
      hold_cnt   <= hold_cnt - 1'b1;
      soft_rst_n <= 1'b0;
    end
    else
    begin
      soft_rst_n <= 1'b1;
    end
  end

endmodule

// File: verilog/host_chan_emul.sv
// ======================================================================
// Host channel emulator. One command per cycle, no back-pressure.
// All outputs are registered, one edge after the command is sampled.
// Commands sampled while rst_n (the platform reset) is low are dropped.
// A command in the cycle right after a soft reset is still decoded.
// ======================================================================

`timescale 1ns/1ns

module host_chan_emul
  (
    input  logic                pClk,
    input  logic                rst_n,

    input  logic                host_cmd_valid,
    input  plat_pkg::host_cmd_t host_cmd,

    output logic                soft_reset_req,

    output logic                g0_req_valid,
    output plat_pkg::mem_req_t  g0_req,
    output plat_pkg::g0_word_t  g0_wr_data,

    output logic                g1_req_valid,
    output plat_pkg::mem_req_t  g1_req,
    output plat_pkg::g1_word_t  g1_wr_data
  );

  // Decoded opcode, before the output register
  logic dec_g0;
  logic dec_g1;
  logic dec_soft;
  logic dec_rd;

  always_comb
  begin
    dec_g0   = 1'b0;
    dec_g1   = 1'b0;
    dec_soft = 1'b0;
    dec_rd   = 1'b0;
    case (host_cmd.op)
      plat_pkg::op_wr_g0:      dec_g0   = 1'b1;
      plat_pkg::op_wr_g1:      dec_g1   = 1'b1;
      plat_pkg::op_rd:         dec_rd   = 1'b1;
      plat_pkg::op_soft_reset: dec_soft = 1'b1;
      default:                 dec_rd   = 1'b0;
    endcase
  end

  // ====================================================================
  // Strobes
  // ====================================================================

  always_ff @(posedge pClk)
  begin
    if (!rst_n)
    begin
      soft_reset_req <= 1'b0;
      g0_req_valid   <= 1'b0;
      g1_req_valid   <= 1'b0;
    end
    else
    begin
      soft_reset_req <= host_cmd_valid && dec_soft;
      // A read goes to both groups at once
      g0_req_valid   <= host_cmd_valid && (dec_g0 || dec_rd);
      g1_req_valid   <= host_cmd_valid && (dec_g1 || dec_rd);
    end
  end

  // Payload follows the command, qualified by the strobes above
  always_ff @(posedge pClk)
  begin
    g0_req.wr_en <= dec_g0;
    g0_req.addr  <= host_cmd.addr;
    g0_wr_data   <= host_cmd.data;

    g1_req.wr_en <= dec_g1;
    g1_req.addr  <= host_cmd.addr;
    // Group 1 keeps the low half of the command data
    g1_wr_data   <= host_cmd.data[plat_pkg::g1_word_w-1:0];
  end

endmodule

// File: verilog/local_mem_bank.sv
// ======================================================================
// Local memory bank model holding 2**mem_addr_w words of type word_t.
// A read returns read_latency edges after the request is sampled.
// Reset drops reads in flight but keeps the memory contents.
// read_latency must be at least 1.
// ======================================================================

`timescale 1ns/1ns

module local_mem_bank
  #(
    parameter type word_t       = logic [31:0],
    parameter int  read_latency = 2
  )
  (
    input  logic                            pClk,
    input  logic                            rst_n,

    input  logic                            req_valid,
    input  plat_pkg::mem_req_t              req,
    input  word_t                           wr_data,

    output logic                            rd_valid,
    output logic [plat_pkg::mem_addr_w-1:0] rd_addr,
    output word_t                           rd_data
  );

  localparam int depth = 2 ** plat_pkg::mem_addr_w;

  word_t mem [depth];

  // Read pipeline with the array output in stage 0
  logic [read_latency-1:0]                           pipe_valid;
  logic [read_latency-1:0][plat_pkg::mem_addr_w-1:0] pipe_addr;
  word_t                                             pipe_data [read_latency];

  always_ff @(posedge pClk)
  begin
    if (req_valid && req.wr_en)
    begin
      mem[req.addr] <= wr_data;
    end
  end

  always_ff @(posedge pClk)
  begin
    if (!rst_n)
    begin
      pipe_valid <= '0;
    end
    else
    begin
      pipe_valid[0] <= req_valid && !req.wr_en;
      for (int i = 1; i < read_latency; i++)
      begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end
  end

  always_ff @(posedge pClk)
  begin
    pipe_addr[0] <= req.addr;
    pipe_data[0] <= mem[req.addr];
    for (int i = 1; i < read_latency; i++)
    begin
      pipe_addr[i] <= pipe_addr[i-1];
      pipe_data[i] <= pipe_data[i-1];
    end
  end

  assign rd_valid = pipe_valid[read_latency-1];
  assign rd_addr  = pipe_addr[read_latency-1];
  assign rd_data  = pipe_data[read_latency-1];

endmodule

// File: verilog/afu_combine.sv
// ======================================================================
// AFU. Pairs group-0 and group-1 read results in arrival order and
// returns their sum with the group-0 address. Both groups must see the
// same read sequence. Queues do not check overflow; with the fixed bank
// latencies group 0 runs at most one entry ahead.
// ======================================================================

`timescale 1ns/1ns

module afu_combine
  (
    input  logic                            pClk,
    input  logic                            rst_n,

    input  logic                            g0_rd_valid,
    input  logic [plat_pkg::mem_addr_w-1:0] g0_rd_addr,
    input  plat_pkg::g0_word_t              g0_rd_data,

    input  logic                            g1_rd_valid,
    input  plat_pkg::g1_word_t              g1_rd_data,

    output logic                            host_rsp_valid,
    output plat_pkg::host_rsp_t             host_rsp
  );

  localparam int qd    = plat_pkg::afu_queue_depth;
  localparam int ptr_w = $clog2(qd);
  localparam int cnt_w = $clog2(qd + 1);

  // Queue storage
  logic [plat_pkg::mem_addr_w-1:0] g0_addr_q [qd];
  plat_pkg::g0_word_t              g0_data_q [qd];
  plat_pkg::g1_word_t              g1_data_q [qd];

  logic [ptr_w-1:0] g0_wr_ptr;
  logic [ptr_w-1:0] g0_rd_ptr;
  logic [cnt_w-1:0] g0_cnt;
  logic [ptr_w-1:0] g1_wr_ptr;
  logic [ptr_w-1:0] g1_rd_ptr;
  logic [cnt_w-1:0] g1_cnt;

  logic pop;

  assign pop = (g0_cnt != '0) && (g1_cnt != '0);

  // ====================================================================
  // Queue control
  // ====================================================================

  always_ff @(posedge pClk)
  begin
    if (!rst_n)
    begin
      g0_wr_ptr <= '0;
      g0_rd_ptr <= '0;
      g0_cnt    <= '0;
      g1_wr_ptr <= '0;
      g1_rd_ptr <= '0;
      g1_cnt    <= '0;
    end
    else
    begin
      if (g0_rd_valid)
        g0_wr_ptr <= g0_wr_ptr + 1'b1;
      if (g1_rd_valid)
        g1_wr_ptr <= g1_wr_ptr + 1'b1;
      if (pop)
      begin
        g0_rd_ptr <= g0_rd_ptr + 1'b1;
        g1_rd_ptr <= g1_rd_ptr + 1'b1;
      end
      g0_cnt <= g0_cnt + cnt_w'(g0_rd_valid) - cnt_w'(pop);
      g1_cnt <= g1_cnt + cnt_w'(g1_rd_valid) - cnt_w'(pop);
    end
  end

  always_ff @(posedge pClk)
  begin
    if (g0_rd_valid)
    begin
      g0_addr_q[g0_wr_ptr] <= g0_rd_addr;
      g0_data_q[g0_wr_ptr] <= g0_rd_data;
    end
    if (g1_rd_valid)
    begin
      g1_data_q[g1_wr_ptr] <= g1_rd_data;
    end
  end

  // ====================================================================
  // Response
  // ====================================================================

  always_ff @(posedge pClk)
  begin
    if (!rst_n)
      host_rsp_valid <= 1'b0;
    else
      host_rsp_valid <= pop;
  end

  // Sum wraps at 64 bits
  always_ff @(posedge pClk)
  begin
    host_rsp.addr <= g0_addr_q[g0_rd_ptr];
    host_rsp.data <= g0_data_q[g0_rd_ptr] + plat_pkg::g0_word_w'(g1_data_q[g1_rd_ptr]);
  end

endmodule

// File: verilog/plat_top.sv
// ======================================================================
// Platform top level on a single clock, pClk. Host commands are one-
// cycle strobes with no ready. A read answers 5 cycles after its
// command is sampled. A soft reset drops reads in flight and keeps the
// local memory contents.
// ======================================================================

`timescale 1ns/1ns

module plat_top
  (
    input  logic                pClk,
    input  logic                rst_n,

    input  logic                host_cmd_valid,
    input  plat_pkg::host_cmd_t host_cmd,

    output logic                host_rsp_valid,
    output plat_pkg::host_rsp_t host_rsp
  );

  logic soft_rst_n;
  logic soft_reset_req;

  logic                            g0_req_valid;
  plat_pkg::mem_req_t              g0_req;
  plat_pkg::g0_word_t              g0_wr_data;
  logic                            g0_rd_valid;
  logic [plat_pkg::mem_addr_w-1:0] g0_rd_addr;
  plat_pkg::g0_word_t              g0_rd_data;

  logic                            g1_req_valid;
  plat_pkg::mem_req_t              g1_req;
  plat_pkg::g1_word_t              g1_wr_data;
  logic                            g1_rd_valid;
  plat_pkg::g1_word_t              g1_rd_data;

  // ====================================================================
  // Reset and host channel
  // ====================================================================

  plat_reset_gen i_reset_gen
    (
      .pClk           (pClk),
      .rst_n          (rst_n),
      .soft_reset_req (soft_reset_req),
      .soft_rst_n     (soft_rst_n)
    );

  host_chan_emul i_host_chan
    (
      .pClk           (pClk),
      .rst_n          (soft_rst_n),
      .host_cmd_valid (host_cmd_valid),
      .host_cmd       (host_cmd),
      .soft_reset_req (soft_reset_req),
      .g0_req_valid   (g0_req_valid),
      .g0_req         (g0_req),
      .g0_wr_data     (g0_wr_data),
      .g1_req_valid   (g1_req_valid),
      .g1_req         (g1_req),
      .g1_wr_data     (g1_wr_data)
    );

  // ====================================================================
  // Local memory groups
  // ====================================================================

  local_mem_bank
    #(
      .word_t       (plat_pkg::g0_word_t),
      .read_latency (plat_pkg::g0_read_latency)
    )
    mem_g0
    (
      .pClk      (pClk),
      .rst_n     (soft_rst_n),
      .req_valid (g0_req_valid),
      .req       (g0_req),
      .wr_data   (g0_wr_data),
      .rd_valid  (g0_rd_valid),
      .rd_addr   (g0_rd_addr),
      .rd_data   (g0_rd_data)
    );

  // Group-1 address is not needed, the AFU pairs results in order
  local_mem_bank
    #(
      .word_t       (plat_pkg::g1_word_t),
      .read_latency (plat_pkg::g1_read_latency)
    )
    mem_g1
    (
      .pClk      (pClk),
      .rst_n     (soft_rst_n),
      .req_valid (g1_req_valid),
      .req       (g1_req),
      .wr_data   (g1_wr_data),
      .rd_valid  (g1_rd_valid),
      .rd_addr   (),
      .rd_data   (g1_rd_data)
    );

  // ====================================================================
  // AFU
  // ====================================================================

  afu_combine i_afu
    (
      .pClk           (pClk),
      .rst_n          (soft_rst_n),
      .g0_rd_valid    (g0_rd_valid),
      .g0_rd_addr     (g0_rd_addr),
      .g0_rd_data     (g0_rd_data),
      .g1_rd_valid    (g1_rd_valid),
      .g1_rd_data     (g1_rd_data),
      .host_rsp_valid (host_rsp_valid),
      .host_rsp       (host_rsp)
    );

endmodule

// File: sim/plat_checker.sv
// ======================================================================
// Response checker for plat_top, sampled at the rising edge. Keeps its
// own copy of both memory groups and expects each read answered 5
// edges after its command edge. A soft reset drops reads in flight and
// opens a 4-cycle window in which commands are ignored.
// ======================================================================

`timescale 1ns/1ns

module plat_checker
  (
    input  logic                pClk,
    input  logic                rst_n,
    input  logic                host_cmd_valid,
    input  plat_pkg::host_cmd_t host_cmd,
    input  logic                host_rsp_valid,
    input  plat_pkg::host_rsp_t host_rsp,
    output int                  err_cnt,
    output int                  rsp_cnt,
    output int                  pending
  );

  localparam int rsp_latency = 5;
  localparam int depth       = 2 ** plat_pkg::mem_addr_w;

  typedef struct packed {
    int                              due;
    logic [plat_pkg::mem_addr_w-1:0] addr;
    plat_pkg::g0_word_t              data;
  } exp_rsp_t;

  plat_pkg::g0_word_t g0_model [depth];
  plat_pkg::g1_word_t g1_model [depth];
  exp_rsp_t           exp_q [$];
  string              cur_test = "none";
  int                 cyc;
  // Edges whose commands the platform drops
  int                 win_lo = 1;
  int                 win_hi = 0;
  int                 rd_drop_at = -1;

  task automatic set_test(input string name);
    cur_test = name;
  endtask

  task automatic report(input string what);
    err_cnt++;
    $display("ERROR %s: %s", cur_test, what);
  endtask

  task automatic mismatch(input string field, input logic [63:0] exp_val,
                          input logic [63:0] act_val);
    err_cnt++;
    $display("MISMATCH %s: %s expected 0x%016h actual 0x%016h",
             cur_test, field, exp_val, act_val);
  endtask

  // ====================================================================
  // Responses, launched at the previous edge
  // ====================================================================

  task automatic check_rsp();
    exp_rsp_t e;
    while (exp_q.size() > 0 && exp_q[0].due < cyc - 1)
    begin
      e = exp_q.pop_front();
      report($sformatf("no response for the read of addr 0x%02h due at cycle %0d",
                       e.addr, e.due));
    end
    if (host_rsp_valid === 1'b1)
    begin
      rsp_cnt++;
      if (exp_q.size() == 0)
      begin
        report($sformatf("unexpected response for addr 0x%02h at cycle %0d",
                         host_rsp.addr, cyc - 1));
      end
      else
      begin
        e = exp_q.pop_front();
        if (e.due != cyc - 1)
          report($sformatf("response at cycle %0d came before its read was due at cycle %0d",
                           cyc - 1, e.due));
        if (host_rsp.addr !== e.addr)
          mismatch("addr", 64'(e.addr), 64'(host_rsp.addr));
        if (host_rsp.data !== e.data)
          mismatch($sformatf("data at addr 0x%02h", e.addr), e.data, host_rsp.data);
      end
    end
    else if (host_rsp_valid !== 1'b0)
    begin
      report("host_rsp_valid is unknown");
    end
  endtask

  // ====================================================================
  // Commands sampled at this edge
  // ====================================================================

  task automatic take_cmd();
    exp_rsp_t                        e;
    logic [plat_pkg::mem_addr_w-1:0] a;
    if (!host_cmd_valid || (cyc >= win_lo && cyc <= win_hi))
      return;
    a = host_cmd.addr;
    case (host_cmd.op)
      plat_pkg::op_wr_g0:
        g0_model[a] = host_cmd.data;
      plat_pkg::op_wr_g1:
        g1_model[a] = host_cmd.data[plat_pkg::g1_word_w-1:0];
      plat_pkg::op_rd:
      begin
        // Read on the edge after a soft reset dies in the bank pipeline
        if (cyc != rd_drop_at)
        begin
          e.due  = cyc + rsp_latency;
          e.addr = a;
          e.data = g0_model[a]
                   + {{(plat_pkg::g0_word_w - plat_pkg::g1_word_w){1'b0}}, g1_model[a]};
          exp_q.push_back(e);
        end
      end
      plat_pkg::op_soft_reset:
      begin
        // Answers launched up to the next edge still get out
        while (exp_q.size() > 0 && exp_q[exp_q.size()-1].due > cyc + 1)
          exp_q.delete(exp_q.size() - 1);
        if (win_hi < cyc)
          win_lo = cyc + 2;
        win_hi     = cyc + 1 + plat_pkg::soft_reset_cycles;
        rd_drop_at = cyc + 1;
      end
      default:
        ;
    endcase
  endtask

  always @(posedge pClk)
  begin
    cyc = cyc + 1;
    if (!rst_n)
    begin
      // Board reset reaches the platform reset one edge late
      exp_q.delete();
      if (win_hi < cyc)
        win_lo = cyc;
      win_hi = cyc + 1;
    end
    else
    begin
      check_rsp();
      take_cmd();
    end
    pending = exp_q.size();
  end

endmodule

// File: sim/tb_plat_top.sv
// ======================================================================
// Testbench for plat_top. Random commands from a fixed seed, checked
// by plat_checker. Tests run in a fixed order, and later tests read
// addresses that fill_and_read has written. The run is bounded by a
// cycle limit taken from the test lengths.
// ======================================================================

`timescale 1ns/1ns

module tb_plat_top;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 3;
  localparam int num_tests    = 5;

  // Test lengths in driven cycles
  localparam int quiet_cycles = 10;
  localparam int fill_cmds    = 3 * (2 ** plat_pkg::mem_addr_w);
  localparam int stream_cmds  = 200;
  localparam int trunc_pairs  = 32;
  localparam int soft_rounds  = 2;
  localparam int round_cycles = 17;

  localparam int cycle_limit = reset_cycles + quiet_cycles + fill_cmds + stream_cmds
                               + 2 * trunc_pairs + soft_rounds * round_cycles
                               + 20 * num_tests;

  logic                pClk;
  logic                rst_n;
  logic                host_cmd_valid;
  plat_pkg::host_cmd_t host_cmd;
  logic                host_rsp_valid;
  plat_pkg::host_rsp_t host_rsp;

  int     err_cnt;
  int     rsp_cnt;
  int     pending;
  integer seed;
  int     cycle_cnt;
  int     tests_run;
  int     test_cmds;
  int     test_err0;
  int     test_rsp0;
  string  cur_name;

  plat_top i_plat_top
    (
      .pClk           (pClk),
      .rst_n          (rst_n),
      .host_cmd_valid (host_cmd_valid),
      .host_cmd       (host_cmd),
      .host_rsp_valid (host_rsp_valid),
      .host_rsp       (host_rsp)
    );

  plat_checker i_checker
    (
      .pClk           (pClk),
      .rst_n          (rst_n),
      .host_cmd_valid (host_cmd_valid),
      .host_cmd       (host_cmd),
      .host_rsp_valid (host_rsp_valid),
      .host_rsp       (host_rsp),
      .err_cnt        (err_cnt),
      .rsp_cnt        (rsp_cnt),
      .pending        (pending)
    );

  initial
  begin
    pClk = 1'b0;
    forever
      #(clk_period / 2) pClk = ~pClk;
  end

  // Watchdog
  always @(posedge pClk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  // ====================================================================
  // Stimulus helpers
  // ====================================================================

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic send_cmd(input plat_pkg::host_op_t op, input logic [7:0] addr,
                          input logic [63:0] data);
    @(negedge pClk);
    host_cmd_valid = 1'b1;
    host_cmd.op    = op;
    host_cmd.addr  = addr;
    host_cmd.data  = data;
    test_cmds++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge pClk);
      host_cmd_valid = 1'b0;
      host_cmd       = '0;
    end
  endtask

  task automatic start_test(input string name);
    cur_name  = name;
    test_cmds = 0;
    test_err0 = err_cnt;
    test_rsp0 = rsp_cnt;
    i_checker.set_test(name);
  endtask

  // Wait for every expected response, then watch a few idle cycles
  task automatic end_test();
    idle_cycles(1);
    while (pending != 0)
      @(negedge pClk);
    idle_cycles(8);
    tests_run++;
    $display("test %-16s done: %0d commands, %0d responses, %0d errors",
             cur_name, test_cmds, rsp_cnt - test_rsp0, err_cnt - test_err0);
  endtask

  // ====================================================================
  // Tests
  // ====================================================================

  task automatic fill_and_read();
    start_test("fill_and_read");
    for (int a = 0; a < 2 ** plat_pkg::mem_addr_w; a++)
    begin
      send_cmd(plat_pkg::op_wr_g0, 8'(a), rand64());
      send_cmd(plat_pkg::op_wr_g1, 8'(a), rand64());
    end
    for (int a = 0; a < 2 ** plat_pkg::mem_addr_w; a++)
      send_cmd(plat_pkg::op_rd, 8'(a), '0);
    end_test();
  endtask

  // Narrow address range so reads often follow writes to the same word
  task automatic streaming_reads();
    logic [31:0] r;
    start_test("streaming_reads");
    for (int i = 0; i < stream_cmds; i++)
    begin
      r = $random(seed);
      if (r[3:0] < 4'd9)
        send_cmd(plat_pkg::op_rd, {4'h0, r[11:8]}, '0);
      else if (r[3:0] < 4'd13)
        send_cmd(plat_pkg::op_wr_g0, {4'h0, r[11:8]}, rand64());
      else
        send_cmd(plat_pkg::op_wr_g1, {4'h0, r[11:8]}, rand64());
    end
    end_test();
  endtask

  task automatic g1_truncation();
    logic [31:0] r;
    logic [63:0] d;
    start_test("g1_truncation");
    for (int i = 0; i < trunc_pairs; i++)
    begin
      r     = $random(seed);
      d     = rand64();
      // Upper half never zero
      d[63] = 1'b1;
      send_cmd(plat_pkg::op_wr_g1, r[7:0], d);
      send_cmd(plat_pkg::op_rd, r[7:0], '0);
    end
    end_test();
  endtask

  task automatic soft_reset_drop();
    logic [7:0]  sel_addr [4];
    logic [31:0] r;
    start_test("soft_reset_drop");
    for (int round = 0; round < soft_rounds; round++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        r           = $random(seed);
        sel_addr[i] = r[7:0];
      end
      // The last three reads are still in flight at the soft reset
      for (int i = 0; i < 5; i++)
      begin
        r = $random(seed);
        send_cmd(plat_pkg::op_rd, r[7:0], '0);
      end
      send_cmd(plat_pkg::op_soft_reset, '0, '0);
      idle_cycles(1);
      // Inside the reset window, none of these may take effect
      send_cmd(plat_pkg::op_wr_g0, sel_addr[0], rand64());
      send_cmd(plat_pkg::op_wr_g1, sel_addr[1], rand64());
      send_cmd(plat_pkg::op_rd, sel_addr[2], '0);
      send_cmd(plat_pkg::op_wr_g0, sel_addr[3], rand64());
      idle_cycles(2);
      for (int i = 0; i < 4; i++)
        send_cmd(plat_pkg::op_rd, sel_addr[i], '0);
    end
    end_test();
  endtask

  // ====================================================================
  // Sequence
  // ====================================================================

  initial
  begin
    seed           = 32'hda660ec8;
    rst_n          = 1'b0;
    host_cmd_valid = 1'b0;
    host_cmd       = '0;

    start_test("reset_quiet");
    repeat (reset_cycles)
      @(posedge pClk);
    @(negedge pClk);
    rst_n = 1'b1;
    idle_cycles(quiet_cycles);
    end_test();

    fill_and_read();
    streaming_reads();
    g1_truncation();
    soft_reset_drop();

    $display("summary: %0d tests, %0d responses, %0d errors", tests_run, rsp_cnt, err_cnt);
    if (err_cnt == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: tb.f
verilog/plat_pkg.sv
verilog/plat_reset_gen.sv
verilog/host_chan_emul.sv
verilog/local_mem_bank.sv
verilog/afu_combine.sv
verilog/plat_top.sv
sim/plat_checker.sv
sim/tb_plat_top.sv

// File: Bender.yml
package:
  name: plat_top

sources:
  - files:
      - verilog/plat_pkg.sv
      - verilog/plat_reset_gen.sv
      - verilog/host_chan_emul.sv
      - verilog/local_mem_bank.sv
      - verilog/afu_combine.sv
      - verilog/plat_top.sv

  - target: simulation
    files:
      - sim/plat_checker.sv
      - sim/tb_plat_top.sv
